// ==== source/bp_pkg.sv ====
package bp_pkg;

    // 2-bit saturating counter, taken in the upper half
    typedef enum logic [1:0] {
        STRONG_NOT   = 2'b00,
        WEAK_NOT     = 2'b01,
        WEAK_TAKEN   = 2'b10,
        STRONG_TAKEN = 2'b11
    } ctr_state_t;

    // Counter value of a fresh or replaced entry
    localparam ctr_state_t CTR_RESET = WEAK_NOT;

    // Fixed-size instructions
    localparam int unsigned INSTR_BYTES = 4;

    // Low address bits that are always zero
    localparam int unsigned ALIGN_BITS = 2;

endpackage

// ==== source/fetch_pc_gen.sv ====
`timescale 1ns/100ps

module fetch_pc_gen #(
    parameter int unsigned ADDR_WIDTH = 32,
    parameter logic [ADDR_WIDTH-1:0] RESET_PC = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  pred_hit,
    input  logic                  pred_taken,
    input  logic [ADDR_WIDTH-1:0] pred_target,
    input  logic                  redirect_valid,
    input  logic [ADDR_WIDTH-1:0] redirect_pc,
    output logic [ADDR_WIDTH-1:0] pc
);

    logic [ADDR_WIDTH-1:0] seq_pc;
    logic [ADDR_WIDTH-1:0] next_pc;

    assign seq_pc = pc + ADDR_WIDTH'(bp_pkg::INSTR_BYTES);

    // Redirect beats stall, stall beats prediction
    always_comb begin
        if (redirect_valid) begin
            next_pc = redirect_pc;
        end else if (stall) begin
            next_pc = pc;
        end else if (pred_hit && pred_taken) begin
            next_pc = pred_target;
        end else begin
            next_pc = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // Redirects and trained targets must keep fetch word aligned
    pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[bp_pkg::ALIGN_BITS-1:0] == '0
    ) else $error("fetch pc %h not instruction aligned", pc);

endmodule

// ==== source/branch_predictor.sv ====
`timescale 1ns/100ps

module branch_predictor #(
    parameter int unsigned ADDR_WIDTH = 32,
    parameter int unsigned INDEX_BITS = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] lookup_pc,
    output logic                  pred_hit,
    output logic                  pred_taken,
    output logic [ADDR_WIDTH-1:0] pred_target,
    input  logic                  train_valid,
    input  logic                  train_taken,
    input  logic [ADDR_WIDTH-1:0] train_pc,
    input  logic [ADDR_WIDTH-1:0] train_target
);

    localparam int unsigned DEPTH     = 2 ** INDEX_BITS;
    localparam int unsigned WORD_BITS = ADDR_WIDTH - bp_pkg::ALIGN_BITS;

    // Table storage, tags and targets are word addresses
    logic [DEPTH-1:0]     entry_valid;
    logic [WORD_BITS-1:0] entry_tag    [DEPTH];
    logic [WORD_BITS-1:0] entry_target [DEPTH];
    bp_pkg::ctr_state_t   entry_ctr    [DEPTH];

    logic [WORD_BITS-1:0]  lookup_word;
    logic [INDEX_BITS-1:0] lookup_idx;
    logic [WORD_BITS-1:0]  train_word;
    logic [INDEX_BITS-1:0] train_idx;
    logic                  train_hit;
    bp_pkg::ctr_state_t    train_base;

    function automatic bp_pkg::ctr_state_t ctr_step(
        input bp_pkg::ctr_state_t cur,
        input logic               taken
    );
        bp_pkg::ctr_state_t nxt;
        case (cur)
            bp_pkg::STRONG_NOT:   nxt = taken ? bp_pkg::WEAK_NOT     : bp_pkg::STRONG_NOT;
            bp_pkg::WEAK_NOT:     nxt = taken ? bp_pkg::WEAK_TAKEN   : bp_pkg::STRONG_NOT;
            bp_pkg::WEAK_TAKEN:   nxt = taken ? bp_pkg::STRONG_TAKEN : bp_pkg::WEAK_NOT;
            bp_pkg::STRONG_TAKEN: nxt = taken ? bp_pkg::STRONG_TAKEN : bp_pkg::WEAK_TAKEN;
            default:              nxt = bp_pkg::CTR_RESET;
        endcase
        return nxt;
    endfunction

    // Lookup path
    assign lookup_word = lookup_pc[ADDR_WIDTH-1:bp_pkg::ALIGN_BITS];
    assign lookup_idx  = lookup_word[INDEX_BITS-1:0];

    assign pred_hit    = entry_valid[lookup_idx] && (entry_tag[lookup_idx] == lookup_word);
    assign pred_taken  = (entry_ctr[lookup_idx] == bp_pkg::WEAK_TAKEN) ||
                         (entry_ctr[lookup_idx] == bp_pkg::STRONG_TAKEN);
    assign pred_target = {entry_target[lookup_idx], {bp_pkg::ALIGN_BITS{1'b0}}};

    // Training path
    assign train_word = train_pc[ADDR_WIDTH-1:bp_pkg::ALIGN_BITS];
    assign train_idx  = train_word[INDEX_BITS-1:0];
    assign train_hit  = entry_valid[train_idx] && (entry_tag[train_idx] == train_word);

    // A replaced entry forgets the old branch's history
    assign train_base = train_hit ? entry_ctr[train_idx] : bp_pkg::CTR_RESET;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                entry_valid[i] <= 1'b0;
                entry_ctr[i]   <= bp_pkg::CTR_RESET;
            end
        end else if (train_valid) begin
            entry_valid[train_idx] <= 1'b1;
            entry_ctr[train_idx]   <= ctr_step(train_base, train_taken);
        end
    end

    always_ff @(posedge clk) begin
        if (train_valid) begin
            entry_tag[train_idx]    <= train_word;
            entry_target[train_idx] <= train_target[ADDR_WIDTH-1:bp_pkg::ALIGN_BITS];
        end
    end

    // Resolver must hand over a known address with every write
    train_pc_known: assert property (
        @(posedge clk) disable iff (reset)
        train_valid |-> !$isunknown(train_pc)
    ) else $error("training write with unknown pc");

endmodule

// ==== source/fetch_output_stage.sv ====
`timescale 1ns/100ps

module fetch_output_stage #(
    parameter int unsigned ADDR_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] pc,
    input  logic                  pred_taken_in,
    input  logic [ADDR_WIDTH-1:0] pred_target_in,
    input  logic                  flush,
    input  logic                  fetch_ready,
    output logic                  stall,
    output logic                  fetch_valid,
    output logic [ADDR_WIDTH-1:0] fetch_pc,
    output logic [ADDR_WIDTH-1:0] fetch_pred_target,
    output logic                  fetch_pred_taken
);

    // Decode refuses the held fetch
    assign stall = fetch_valid && !fetch_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else if (flush) begin
            fetch_valid <= 1'b0;
        end else if (!stall) begin
            fetch_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fetch_pc          <= pc;
            fetch_pred_taken  <= pred_taken_in;
            fetch_pred_target <= pred_target_in;
        end
    end

    // Held fetch and the pc behind it stay put until decode takes it or a flush drops it
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (reset)
        (fetch_valid && !fetch_ready && !flush) |=>
            (fetch_valid && $stable(fetch_pc) && $stable(fetch_pred_taken) &&
             $stable(fetch_pred_target) && $stable(pc))
    ) else $error("fetch outputs or pc changed under back-pressure");

endmodule

// ==== source/branch_resolver.sv ====
`timescale 1ns/100ps

module branch_resolver #(
    parameter int unsigned ADDR_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  resolve_valid,
    input  logic                  resolve_taken,
    input  logic                  resolve_pred_taken,
    input  logic [ADDR_WIDTH-1:0] resolve_pc,
    input  logic [ADDR_WIDTH-1:0] resolve_target,
    input  logic [ADDR_WIDTH-1:0] resolve_pred_target,
    output logic                  train_valid,
    output logic                  train_taken,
    output logic [ADDR_WIDTH-1:0] train_pc,
    output logic [ADDR_WIDTH-1:0] train_target,
    output logic                  redirect_valid,
    output logic [ADDR_WIDTH-1:0] redirect_pc
);

    logic                  dir_wrong;
    logic                  target_wrong;
    logic                  mispredicted;
    logic [ADDR_WIDTH-1:0] fall_through;
    logic [ADDR_WIDTH-1:0] correct_pc;

    assign dir_wrong    = resolve_taken != resolve_pred_taken;
    // Only a taken branch can go to the wrong place
    assign target_wrong = resolve_taken && (resolve_target != resolve_pred_target);
    assign mispredicted = dir_wrong || target_wrong;

    assign fall_through = resolve_pc + ADDR_WIDTH'(bp_pkg::INSTR_BYTES);
    assign correct_pc   = resolve_taken ? resolve_target : fall_through;

    always_ff @(posedge clk) begin
        if (reset) begin
            train_valid    <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            train_valid    <= resolve_valid;
            redirect_valid <= resolve_valid && mispredicted;
        end
    end

    always_ff @(posedge clk) begin
        if (resolve_valid) begin
            train_taken  <= resolve_taken;
            train_pc     <= resolve_pc;
            train_target <= resolve_target;
            redirect_pc  <= correct_pc;
        end
    end

endmodule

// ==== source/bp_frontend.sv ====
`timescale 1ns/100ps

module bp_frontend #(
    parameter int unsigned ADDR_WIDTH = 32,
    parameter int unsigned INDEX_BITS = 4,
    parameter logic [ADDR_WIDTH-1:0] RESET_PC = 'h100
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fetch_ready,
    output logic                  fetch_valid,
    output logic [ADDR_WIDTH-1:0] fetch_pc,
    output logic                  fetch_pred_taken,
    output logic [ADDR_WIDTH-1:0] fetch_pred_target,
    input  logic                  resolve_valid,
    input  logic [ADDR_WIDTH-1:0] resolve_pc,
    input  logic                  resolve_taken,
    input  logic [ADDR_WIDTH-1:0] resolve_target,
    input  logic                  resolve_pred_taken,
    input  logic [ADDR_WIDTH-1:0] resolve_pred_target,
    output logic                  mispredict
);

    logic [ADDR_WIDTH-1:0] pc;
    logic                  pred_hit;
    logic                  pred_taken;
    logic [ADDR_WIDTH-1:0] pred_target;
    logic                  stall;
    logic                  train_valid;
    logic                  train_taken;
    logic [ADDR_WIDTH-1:0] train_pc;
    logic [ADDR_WIDTH-1:0] train_target;
    logic                  redirect_valid;
    logic [ADDR_WIDTH-1:0] redirect_pc;

    assign mispredict = redirect_valid;

    fetch_pc_gen #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .RESET_PC   (RESET_PC)
    ) u_pc_gen (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .pred_hit       (pred_hit),
        .pred_taken     (pred_taken),
        .pred_target    (pred_target),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .pc             (pc)
    );

    branch_predictor #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .INDEX_BITS (INDEX_BITS)
    ) u_predictor (
        .clk          (clk),
        .reset        (reset),
        .lookup_pc    (pc),
        .pred_hit     (pred_hit),
        .pred_taken   (pred_taken),
        .pred_target  (pred_target),
        .train_valid  (train_valid),
        .train_taken  (train_taken),
        .train_pc     (train_pc),
        .train_target (train_target)
    );

    // Taken is only recorded for a hit
    fetch_output_stage #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_out_stage (
        .clk               (clk),
        .reset             (reset),
        .pc                (pc),
        .pred_taken_in     (pred_hit && pred_taken),
        .pred_target_in    (pred_target),
        .flush             (redirect_valid),
        .fetch_ready       (fetch_ready),
        .stall             (stall),
        .fetch_valid       (fetch_valid),
        .fetch_pc          (fetch_pc),
        .fetch_pred_target (fetch_pred_target),
        .fetch_pred_taken  (fetch_pred_taken)
    );

    branch_resolver #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_resolver (
        .clk                 (clk),
        .reset               (reset),
        .resolve_valid       (resolve_valid),
        .resolve_taken       (resolve_taken),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pc          (resolve_pc),
        .resolve_target      (resolve_target),
        .resolve_pred_target (resolve_pred_target),
        .train_valid         (train_valid),
        .train_taken         (train_taken),
        .train_pc            (train_pc),
        .train_target        (train_target),
        .redirect_valid      (redirect_valid),
        .redirect_pc         (redirect_pc)
    );

endmodule

// ==== verif/bp_frontend_tb.sv ====
`timescale 1ns/100ps

module bp_frontend_tb;

    localparam logic [31:0] RESET_PC = 32'h100;
    localparam int ENTRIES = 16;
    localparam int MAX_CYCLES = 2000;

    logic        clk;
    logic        reset;
    logic        fetch_ready;
    logic        fetch_valid;
    logic [31:0] fetch_pc;
    logic        fetch_pred_taken;
    logic [31:0] fetch_pred_target;
    logic        resolve_valid;
    logic [31:0] resolve_pc;
    logic        resolve_taken;
    logic [31:0] resolve_target;
    logic        resolve_pred_taken;
    logic [31:0] resolve_pred_target;
    logic        mispredict;

    // Reference table with full fetch addresses as tags
    logic               t_valid [ENTRIES];
    logic [31:0]        t_tag   [ENTRIES];
    logic [31:0]        t_tgt   [ENTRIES];
    bp_pkg::ctr_state_t t_ctr   [ENTRIES];

    // Expected pipeline state
    logic [31:0] m_pc;
    logic [31:0] m_fpc;
    logic [31:0] m_ftgt;
    logic [31:0] m_tpc;
    logic [31:0] m_ttgt;
    logic [31:0] m_rpc;
    logic        m_fv;
    logic        m_ftaken;
    logic        m_tv;
    logic        m_ttaken;
    logic        m_rv;

    integer seed = 83192;
    int     cycles = 0;
    int     pass_cnt = 0;
    int     fail_cnt = 0;
    int     fails_at_start;
    string  test_name;
    logic   seen_mispredict;

    bp_frontend DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: tests still running after %0d clock cycles", MAX_CYCLES);
        $display("sim failed");
        $finish;
    end

    function automatic int table_index(input logic [31:0] a);
        return int'(a[5:2]);
    endfunction

    function automatic logic model_hit(input logic [31:0] a);
        return t_valid[table_index(a)] && (t_tag[table_index(a)] == a);
    endfunction

    function automatic logic model_taken(input logic [31:0] a);
        return model_hit(a) && (t_ctr[table_index(a)] >= bp_pkg::WEAK_TAKEN);
    endfunction

    function automatic logic [31:0] model_next(input logic [31:0] a);
        return model_taken(a) ? t_tgt[table_index(a)] : a + 32'd4;
    endfunction

    function automatic logic [31:0] rand_target();
        logic [31:0] r;
        r = $random(seed);
        return 32'h4000 | (r & 32'h0ffc);
    endfunction

    task automatic model_train(input logic [31:0] a, input logic tk, input logic [31:0] tgt);
        int i;
        bp_pkg::ctr_state_t c;
        i = table_index(a);
        c = model_hit(a) ? t_ctr[i] : bp_pkg::CTR_RESET;
        if (tk && c != bp_pkg::STRONG_TAKEN)
            c = bp_pkg::ctr_state_t'(c + 1);
        else if (!tk && c != bp_pkg::STRONG_NOT)
            c = bp_pkg::ctr_state_t'(c - 1);
        t_valid[i] = 1'b1;
        t_tag[i]   = a;
        t_tgt[i]   = tgt;
        t_ctr[i]   = c;
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            fail_cnt++;
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end else begin
            pass_cnt++;
        end
    endtask

    // One clock edge with the model advanced on the inputs the DUT sees at that edge
    task automatic tick();
        logic stall;
        logic [31:0] next_pc;
        stall = m_fv && !fetch_ready;
        if (!stall) begin
            m_fpc    = m_pc;
            m_ftaken = model_taken(m_pc);
            m_ftgt   = t_tgt[table_index(m_pc)];
        end
        if (m_rv)
            next_pc = m_rpc;
        else if (stall)
            next_pc = m_pc;
        else
            next_pc = model_next(m_pc);
        // Output stage is full every cycle except right after a flush
        m_fv = !m_rv;
        if (m_tv)
            model_train(m_tpc, m_ttaken, m_ttgt);
        m_pc = next_pc;
        m_tv = resolve_valid;
        m_tpc = resolve_pc;
        m_ttaken = resolve_taken;
        m_ttgt = resolve_target;
        m_rv = resolve_valid && ((resolve_taken != resolve_pred_taken) ||
               (resolve_taken && resolve_target != resolve_pred_target));
        m_rpc = resolve_taken ? resolve_target : resolve_pc + 32'd4;
        @(posedge clk);
        #1;
        check("fetch_valid", m_fv, fetch_valid);
        check("mispredict", m_rv, mispredict);
        if (m_fv) begin
            check("fetch_pc", m_fpc, fetch_pc);
            check("fetch_pred_taken", m_ftaken, fetch_pred_taken);
            if (m_ftaken)
                check("fetch_pred_target", m_ftgt, fetch_pred_target);
        end
    endtask

    // Pulse one resolve and wait one more edge so training and redirect land
    task automatic resolve(input logic [31:0] a, input logic tk, input logic [31:0] tgt,
                           input logic ptk, input logic [31:0] ptgt);
        resolve_valid = 1'b1;
        resolve_pc = a;
        resolve_taken = tk;
        resolve_target = tgt;
        resolve_pred_taken = ptk;
        resolve_pred_target = ptgt;
        tick();
        seen_mispredict = mispredict;
        resolve_valid = 1'b0;
        tick();
    endtask

    task automatic resolve_model(input logic [31:0] a, input logic tk, input logic [31:0] tgt);
        resolve(a, tk, tgt, model_taken(a), model_hit(a) ? t_tgt[table_index(a)] : 32'h0);
    endtask

    task automatic expect_redirect(input logic [31:0] a);
        check("mispredict raised", 1, seen_mispredict);
        tick();
        check("redirect fetch_valid", 1, fetch_valid);
        check("redirect fetch_pc", a, fetch_pc);
    endtask

    // Not-taken branch just before a that was predicted taken
    task automatic jump_to(input logic [31:0] a);
        resolve(a - 32'd4, 1'b0, a, 1'b1, a);
        expect_redirect(a);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        fails_at_start = fail_cnt;
    endtask

    task automatic end_test();
        $display("%s: %s", test_name, (fail_cnt == fails_at_start) ? "ok" : "FAILED");
    endtask

    task automatic test_sequential();
        start_test("sequential");
        for (int k = 0; k < 6; k++) begin
            tick();
            check("fetch_pc", RESET_PC + 32'(4 * k), fetch_pc);
            check("fetch_pred_taken", 0, fetch_pred_taken);
            check("mispredict", 0, mispredict);
        end
        end_test();
    endtask

    task automatic test_train_taken();
        logic [31:0] t;
        t = rand_target();
        start_test("train_taken");
        resolve_model(32'h140, 1'b1, t);
        expect_redirect(t);
        resolve_model(32'h140, 1'b1, t);
        check("second resolve mispredict", 0, seen_mispredict);
        jump_to(32'h140);
        check("fetch_pred_taken", 1, fetch_pred_taken);
        check("fetch_pred_target", t, fetch_pred_target);
        tick();
        check("fetch after branch", t, fetch_pc);
        end_test();
    endtask

    task automatic test_hysteresis();
        logic [31:0] t;
        t = rand_target();
        start_test("hysteresis");
        repeat (3) resolve_model(32'h188, 1'b1, t);
        resolve_model(32'h188, 1'b0, t);
        expect_redirect(32'h18c);
        jump_to(32'h188);
        check("taken after one not-taken", 1, fetch_pred_taken);
        resolve_model(32'h188, 1'b0, t);
        expect_redirect(32'h18c);
        jump_to(32'h188);
        check("not-taken after two", 0, fetch_pred_taken);
        end_test();
    endtask

    task automatic test_tag_mismatch();
        logic [31:0] t;
        t = rand_target();
        start_test("tag_mismatch");
        // 0x188 and 0x1c8 share index 2
        resolve_model(32'h188, 1'b1, t);
        jump_to(32'h1c8);
        check("other tag predicted", 0, fetch_pred_taken);
        resolve_model(32'h1c8, 1'b1, t);
        expect_redirect(t);
        jump_to(32'h188);
        check("replaced branch predicted", 0, fetch_pred_taken);
        jump_to(32'h1c8);
        check("new branch predicted", 1, fetch_pred_taken);
        check("new branch target", t, fetch_pred_target);
        end_test();
    endtask

    task automatic test_back_pressure();
        logic [31:0] held_pc;
        logic [31:0] held_tgt;
        logic        held_taken;
        start_test("back_pressure");
        jump_to(32'h140);
        held_pc = 32'h140;
        held_tgt = t_tgt[table_index(32'h140)];
        held_taken = model_taken(32'h140);
        fetch_ready = 1'b0;
        repeat (4) begin
            tick();
            check("held fetch_valid", 1, fetch_valid);
            check("held fetch_pc", held_pc, fetch_pc);
            check("held pred_taken", held_taken, fetch_pred_taken);
            check("held pred_target", held_tgt, fetch_pred_target);
        end
        fetch_ready = 1'b1;
        tick();
        check("resumed fetch_pc", model_next(held_pc), fetch_pc);
        tick();
        check("following fetch_pc", model_next(model_next(held_pc)), fetch_pc);
        end_test();
    endtask

    task automatic test_redirect_in_stall();
        logic [31:0] t_old;
        logic [31:0] t_new;
        t_old = rand_target();
        t_new = rand_target();
        if (t_new == t_old)
            t_new = t_old + 32'd4;
        start_test("redirect_in_stall");
        resolve_model(32'h1a0, 1'b1, t_old);
        expect_redirect(t_old);
        fetch_ready = 1'b0;
        tick();
        tick();
        check("held before redirect", 1, fetch_valid);
        resolve_model(32'h1a0, 1'b1, t_new);
        check("flushed fetch_valid", 0, fetch_valid);
        expect_redirect(t_new);
        fetch_ready = 1'b1;
        tick();
        end_test();
    endtask

    initial begin
        reset = 1'b1;
        fetch_ready = 1'b1;
        resolve_valid = 1'b0;
        resolve_pc = '0;
        resolve_taken = 1'b0;
        resolve_target = '0;
        resolve_pred_taken = 1'b0;
        resolve_pred_target = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            t_valid[i] = 1'b0;
            t_tag[i] = '0;
            t_tgt[i] = '0;
            t_ctr[i] = bp_pkg::CTR_RESET;
        end
        m_pc = RESET_PC;
        {m_fv, m_tv, m_rv, m_ftaken, m_ttaken} = '0;
        {m_fpc, m_ftgt, m_tpc, m_ttgt, m_rpc} = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        test_sequential();
        test_train_taken();
        test_hysteresis();
        test_tag_mismatch();
        test_back_pressure();
        test_redirect_in_stall();
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== project.f ====
source/bp_pkg.sv
source/fetch_pc_gen.sv
source/branch_predictor.sv
source/fetch_output_stage.sv
source/branch_resolver.sv
source/bp_frontend.sv
verif/bp_frontend_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the front-end testbench with Verilator, verdict comes from sim.log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module bp_frontend_tb -o bp_frontend_sim > build.log 2>&1 &&
    ./obj_dir/bp_frontend_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^sim passed$" sim.log && echo "RESULT: PASS" ||
    { echo "RESULT: FAIL (see build.log and sim.log)"; exit 1; }
